/* design/sd_cmd_master.sv */
`timescale 1ns/1ps
`include "sd_defines.svh"

module sd_cmd_master (
    input  logic                         sd_clk,
    input  logic                         reset_i,
    input  logic                         soft_reset_i,
    input  logic                         start_i,
    input  sd_pkg::cmd_req_t             cmd_req_i,
    input  logic                         finish_i,
    input  sd_pkg::cmd_result_t          result_i,
    output logic                         host_start_o,
    output sd_pkg::cmd_req_t             host_req_o,
    output logic                         busy_o,
    output sd_pkg::cmd_status_t          status_set_o,
    output logic [3:0][`SD_WB_DAT_W-1:0] response_o
);

    sd_pkg::cmd_master_state_e state_q;
    sd_pkg::cmd_status_t       status_next;
    logic                      master_rst;
    logic                      accept;
    logic                      complete;

    assign master_rst = reset_i | soft_reset_i;
    assign busy_o     = state_q != sd_pkg::MST_IDLE;
    assign accept     = (state_q == sd_pkg::MST_IDLE) & start_i;
    assign complete   = (state_q == sd_pkg::MST_WAIT) & finish_i;

    // Errors are only meaningful when a response actually arrived
    always_comb begin
        status_next = '0;
        status_next[`SD_INT_CMD_DONE]    = 1'b1;
        status_next[`SD_INT_CMD_TIMEOUT] = result_i.timeout;
        status_next[`SD_INT_CMD_CRC]     = ~result_i.timeout & host_req_o.crc_check
                                           & ~result_i.crc_ok;
        status_next[`SD_INT_CMD_INDEX]   = ~result_i.timeout & host_req_o.index_check
                                           & ~result_i.index_ok;
    end

    always_ff @(posedge sd_clk) begin
        if (master_rst) begin
            state_q      <= sd_pkg::MST_IDLE;
            host_start_o <= 1'b0;
            status_set_o <= '0;
        end else begin
            host_start_o <= 1'b0;
            status_set_o <= '0;
            case (state_q)
                sd_pkg::MST_IDLE: begin
                    if (start_i) begin
                        host_start_o <= 1'b1;
                        state_q      <= sd_pkg::MST_ISSUE;
                    end
                end
                sd_pkg::MST_ISSUE: begin
                    state_q <= sd_pkg::MST_WAIT;
                end
                sd_pkg::MST_WAIT: begin
                    if (finish_i) begin
                        status_set_o <= status_next;
                        state_q      <= sd_pkg::MST_IDLE;
                    end
                end
                default: begin
                    state_q <= sd_pkg::MST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sd_clk) begin
        if (accept) begin
            host_req_o <= cmd_req_i;
        end
        // RESP3 carries only the top 24 stored bits
        if (complete) begin
            response_o[0] <= result_i.response[31:0];
            response_o[1] <= result_i.response[63:32];
            response_o[2] <= result_i.response[95:64];
            response_o[3] <= {8'b0, result_i.response[119:96]};
        end
    end

endmodule

/* design/sd_cmd_serial_host.sv */
`timescale 1ns/1ps
`include "sd_defines.svh"

module sd_cmd_serial_host (
    input  logic                sd_clk,
    input  logic                reset_i,
    input  logic                soft_reset_i,
    input  logic                start_i,
    input  sd_pkg::cmd_req_t    cmd_req_i,
    input  logic                cmd_i,
    output logic                cmd_o,
    output logic                cmd_oe_o,
    output logic                finish_o,
    output sd_pkg::cmd_result_t result_o
);

    sd_pkg::cmd_host_state_e   state_q;
    sd_pkg::cmd_req_t          req_q;
    logic                      host_rst;
    logic [39:0]               tx_data;
    logic [39:0]               tx_shift;
    logic [7:0]                bit_cnt;
    logic [7:0]                resp_last;
    logic [7:0]                timeout_cnt;
    logic [6:0]                crc_q;
    logic [6:0]                crc_next;
    logic                      crc_in;
    logic                      rx_fold;
    logic                      is_long;
    logic [`SD_RESP_LONG_W-1:0] resp_shift;
    logic [`SD_RESP_LONG_W-1:0] rx_word;

    // Serial CRC7, x^7 + x^3 + 1
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign host_rst  = reset_i | soft_reset_i;
    assign tx_data   = {1'b0, 1'b1, cmd_req_i.index, cmd_req_i.argument};
    assign is_long   = req_q.resp_type == sd_pkg::RESP_LONG;
    assign resp_last = is_long ? 8'(`SD_RESP_LONG_W - 1) : 8'(`SD_CMD_FRAME_W - 1);

    // Same CRC register serves both directions
    assign crc_in   = (state_q == sd_pkg::HST_SEND) ? cmd_o : cmd_i;
    assign crc_next = crc7_step(crc_q, crc_in);

    // Long responses skip the 8 header bits, both stop before the end bit
    assign rx_fold = (bit_cnt < resp_last) && (!is_long || bit_cnt >= 8'd8);
    assign rx_word = {resp_shift[`SD_RESP_LONG_W-2:0], cmd_i};

    always_ff @(posedge sd_clk) begin
        if (host_rst) begin
            state_q     <= sd_pkg::HST_IDLE;
            cmd_o       <= 1'b1;
            cmd_oe_o    <= 1'b0;
            finish_o    <= 1'b0;
            bit_cnt     <= '0;
            timeout_cnt <= '0;
        end else begin
            finish_o <= 1'b0;
            case (state_q)
                sd_pkg::HST_IDLE: begin
                    if (start_i) begin
                        req_q    <= cmd_req_i;
                        cmd_o    <= tx_data[39];
                        tx_shift <= {tx_data[38:0], 1'b0};
                        cmd_oe_o <= 1'b1;
                        crc_q    <= '0;
                        bit_cnt  <= '0;
                        state_q  <= sd_pkg::HST_SEND;
                    end
                end
                sd_pkg::HST_SEND: begin
                    bit_cnt <= bit_cnt + 8'd1;
                    if (bit_cnt < 8'd39) begin
                        crc_q    <= crc_next;
                        cmd_o    <= tx_shift[39];
                        tx_shift <= {tx_shift[38:0], 1'b0};
                    end else if (bit_cnt == 8'd39) begin
                        // Last payload bit folded, CRC goes out next
                        cmd_o <= crc_next[6];
                        crc_q <= {crc_next[5:0], 1'b0};
                    end else if (bit_cnt < 8'd46) begin
                        cmd_o <= crc_q[6];
                        crc_q <= {crc_q[5:0], 1'b0};
                    end else if (bit_cnt == 8'd46) begin
                        cmd_o <= 1'b1;
                    end else begin
                        cmd_oe_o    <= 1'b0;
                        crc_q       <= '0;
                        bit_cnt     <= '0;
                        timeout_cnt <= '0;
                        if (req_q.resp_type == sd_pkg::RESP_NONE) begin
                            finish_o          <= 1'b1;
                            result_o.response <= '0;
                            result_o.crc_ok   <= 1'b1;
                            result_o.index_ok <= 1'b1;
                            result_o.timeout  <= 1'b0;
                            state_q           <= sd_pkg::HST_IDLE;
                        end else begin
                            state_q <= sd_pkg::HST_WAIT_RESP;
                        end
                    end
                end
                sd_pkg::HST_WAIT_RESP: begin
                    if (!cmd_i) begin
                        resp_shift <= rx_word;
                        if (rx_fold) begin
                            crc_q <= crc_next;
                        end
                        bit_cnt <= 8'd1;
                        state_q <= sd_pkg::HST_RECV;
                    end else if (timeout_cnt == 8'(`SD_RESP_TIMEOUT - 1)) begin
                        finish_o          <= 1'b1;
                        result_o.response <= '0;
                        result_o.crc_ok   <= 1'b0;
                        result_o.index_ok <= 1'b0;
                        result_o.timeout  <= 1'b1;
                        state_q           <= sd_pkg::HST_IDLE;
                    end else begin
                        timeout_cnt <= timeout_cnt + 8'd1;
                    end
                end
                sd_pkg::HST_RECV: begin
                    resp_shift <= rx_word;
                    bit_cnt    <= bit_cnt + 8'd1;
                    if (rx_fold) begin
                        crc_q <= crc_next;
                    end
                    if (bit_cnt == resp_last) begin
                        // CRC bits were folded in, so a good frame leaves zero
                        finish_o         <= 1'b1;
                        result_o.crc_ok  <= crc_q == 7'd0;
                        result_o.timeout <= 1'b0;
                        if (is_long) begin
                            result_o.response <= rx_word[127:8];
                            result_o.index_ok <= 1'b1;
                        end else begin
                            result_o.response <= {{(`SD_RESP_STORE_W - 32){1'b0}},
                                                  rx_word[39:8]};
                            result_o.index_ok <= rx_word[45:40] == req_q.index;
                        end
                        state_q <= sd_pkg::HST_IDLE;
                    end
                end
                default: begin
                    state_q <= sd_pkg::HST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/sd_defines.svh */
`ifndef SD_DEFINES_SVH
`define SD_DEFINES_SVH

// Bus and frame widths
`define SD_WB_ADR_W      8
`define SD_WB_DAT_W      32
`define SD_CMD_FRAME_W   48
`define SD_RESP_LONG_W   136
`define SD_RESP_STORE_W  120

// Cycles to wait for the response start bit
`define SD_RESP_TIMEOUT  64

// Register map
`define SD_REG_ARGUMENT    8'h00
`define SD_REG_COMMAND     8'h04
`define SD_REG_RESP0       8'h08
`define SD_REG_RESP1       8'h0C
`define SD_REG_RESP2       8'h10
`define SD_REG_RESP3       8'h14
`define SD_REG_INT_STATUS  8'h18
`define SD_REG_INT_ENABLE  8'h1C
`define SD_REG_SOFT_RESET  8'h20

// Interrupt status bit positions
`define SD_INT_CMD_DONE     0
`define SD_INT_CMD_TIMEOUT  1
`define SD_INT_CMD_CRC      2
`define SD_INT_CMD_INDEX    3

`endif

/* design/sd_emmc_controller.sv */
`timescale 1ns/1ps
`include "sd_defines.svh"

module sd_emmc_controller (
    input  logic            sd_clk,
    input  logic            reset_i,
    input  sd_pkg::wb_req_t wb_req_i,
    output sd_pkg::wb_rsp_t wb_rsp_o,
    input  logic            cmd_i,
    output logic            cmd_o,
    output logic            cmd_oe_o,
    output logic            interrupt_o
);

    sd_pkg::cmd_req_t             slave_req;
    sd_pkg::cmd_req_t             host_req;
    sd_pkg::cmd_result_t          host_result;
    sd_pkg::cmd_status_t          status_set;
    logic [3:0][`SD_WB_DAT_W-1:0] response;
    logic                         cmd_start;
    logic                         host_start;
    logic                         host_finish;
    logic                         cmd_busy;
    logic                         soft_reset;

    sd_reg_slave u_reg_slave (
        .sd_clk       (sd_clk),
        .reset_i      (reset_i),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .busy_i       (cmd_busy),
        .status_set_i (status_set),
        .response_i   (response),
        .cmd_req_o    (slave_req),
        .start_o      (cmd_start),
        .soft_reset_o (soft_reset),
        .interrupt_o  (interrupt_o)
    );

    sd_cmd_master u_cmd_master (
        .sd_clk       (sd_clk),
        .reset_i      (reset_i),
        .soft_reset_i (soft_reset),
        .start_i      (cmd_start),
        .cmd_req_i    (slave_req),
        .finish_i     (host_finish),
        .result_i     (host_result),
        .host_start_o (host_start),
        .host_req_o   (host_req),
        .busy_o       (cmd_busy),
        .status_set_o (status_set),
        .response_o   (response)
    );

    sd_cmd_serial_host u_cmd_serial_host (
        .sd_clk       (sd_clk),
        .reset_i      (reset_i),
        .soft_reset_i (soft_reset),
        .start_i      (host_start),
        .cmd_req_i    (host_req),
        .cmd_i        (cmd_i),
        .cmd_o        (cmd_o),
        .cmd_oe_o     (cmd_oe_o),
        .finish_o     (host_finish),
        .result_o     (host_result)
    );

endmodule

/* design/sd_pkg.sv */
`include "sd_defines.svh"

package sd_pkg;

    // Encoded in COMMAND[7:6]
    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1,
        RESP_LONG  = 2'd2
    } resp_type_e;

    typedef struct packed {
        logic [5:0]              index;
        logic [31:0]             argument;
        resp_type_e              resp_type;
        logic                    crc_check;
        logic                    index_check;
    } cmd_req_t;

    typedef struct packed {
        logic [`SD_RESP_STORE_W-1:0] response;
        logic                        crc_ok;
        logic                        index_ok;
        logic                        timeout;
    } cmd_result_t;

    // Bit order follows the INT_STATUS layout
    typedef struct packed {
        logic index_err;
        logic crc_err;
        logic timeout;
        logic done;
    } cmd_status_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`SD_WB_ADR_W-1:0] adr;
        logic [`SD_WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [`SD_WB_DAT_W-1:0] dat;
        logic                    ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        MST_IDLE,
        MST_ISSUE,
        MST_WAIT
    } cmd_master_state_e;

    typedef enum logic [1:0] {
        HST_IDLE,
        HST_SEND,
        HST_WAIT_RESP,
        HST_RECV
    } cmd_host_state_e;

endpackage

/* design/sd_reg_slave.sv */
`timescale 1ns/1ps
`include "sd_defines.svh"

module sd_reg_slave (
    input  logic                              sd_clk,
    input  logic                              reset_i,
    input  sd_pkg::wb_req_t                   wb_req_i,
    output sd_pkg::wb_rsp_t                   wb_rsp_o,
    input  logic                              busy_i,
    input  sd_pkg::cmd_status_t               status_set_i,
    input  logic [3:0][`SD_WB_DAT_W-1:0]      response_i,
    output sd_pkg::cmd_req_t                  cmd_req_o,
    output logic                              start_o,
    output logic                              soft_reset_o,
    output logic                              interrupt_o
);

    logic [`SD_WB_DAT_W-1:0] argument_q;
    logic [9:0]              command_q;
    sd_pkg::cmd_status_t     int_status_q;
    sd_pkg::cmd_status_t     int_enable_q;
    sd_pkg::cmd_status_t     clear_mask;
    logic                    ack_q;
    logic [`SD_WB_DAT_W-1:0] rd_data_q;
    logic [`SD_WB_DAT_W-1:0] rd_mux;
    logic                    access;
    logic                    wr_en;
    logic                    launch_q;
    logic                    cmd_pending;
    logic                    sel_argument;
    logic                    sel_command;
    logic                    sel_int_status;
    logic                    sel_int_enable;
    logic                    sel_soft_reset;

    // New access only when no ack is outstanding
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_en  = access & wb_req_i.we;

    assign sel_argument   = wb_req_i.adr == `SD_REG_ARGUMENT;
    assign sel_command    = wb_req_i.adr == `SD_REG_COMMAND;
    assign sel_int_status = wb_req_i.adr == `SD_REG_INT_STATUS;
    assign sel_int_enable = wb_req_i.adr == `SD_REG_INT_ENABLE;
    assign sel_soft_reset = wb_req_i.adr == `SD_REG_SOFT_RESET;

    // Launch in flight counts as busy too
    assign cmd_pending = busy_i | launch_q | start_o;

    assign clear_mask = (wr_en && sel_int_status) ? wb_req_i.dat[3:0] : 4'b0000;

    assign cmd_req_o.index       = command_q[5:0];
    assign cmd_req_o.argument    = argument_q;
    assign cmd_req_o.resp_type   = sd_pkg::resp_type_e'(command_q[7:6]);
    assign cmd_req_o.crc_check   = command_q[8];
    assign cmd_req_o.index_check = command_q[9];

    assign wb_rsp_o.dat = rd_data_q;
    assign wb_rsp_o.ack = ack_q;

    assign interrupt_o = |(int_status_q & int_enable_q);

    always_comb begin
        case (wb_req_i.adr)
            `SD_REG_ARGUMENT:   rd_mux = argument_q;
            `SD_REG_COMMAND:    rd_mux = {22'b0, command_q};
            `SD_REG_RESP0:      rd_mux = response_i[0];
            `SD_REG_RESP1:      rd_mux = response_i[1];
            `SD_REG_RESP2:      rd_mux = response_i[2];
            `SD_REG_RESP3:      rd_mux = response_i[3];
            `SD_REG_INT_STATUS: rd_mux = {28'b0, int_status_q};
            `SD_REG_INT_ENABLE: rd_mux = {28'b0, int_enable_q};
            default:            rd_mux = '0;
        endcase
    end

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            ack_q        <= 1'b0;
            launch_q     <= 1'b0;
            start_o      <= 1'b0;
            soft_reset_o <= 1'b0;
            int_status_q <= '0;
            int_enable_q <= '0;
        end else begin
            ack_q        <= access;
            launch_q     <= wr_en & sel_command & ~cmd_pending;
            start_o      <= launch_q;
            soft_reset_o <= wr_en & sel_soft_reset & wb_req_i.dat[0];
            // A set in the same cycle wins over a clear
            int_status_q <= (int_status_q & ~clear_mask) | status_set_i;
            if (wr_en && sel_int_enable) begin
                int_enable_q <= wb_req_i.dat[3:0];
            end
        end
    end

    always_ff @(posedge sd_clk) begin
        if (wr_en && sel_argument) begin
            argument_q <= wb_req_i.dat;
        end
        // Ignored while a command runs
        if (wr_en && sel_command && !cmd_pending) begin
            command_q <= wb_req_i.dat[9:0];
        end
        if (access) begin
            rd_data_q <= rd_mux;
        end
    end

endmodule

/* files.f */
+incdir+design
design/sd_pkg.sv
design/sd_reg_slave.sv
design/sd_cmd_master.sv
design/sd_cmd_serial_host.sv
design/sd_emmc_controller.sv
test/sd_card_model.sv
test/tb_sd_emmc_controller.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_sd_emmc_controller -o sim
out=$(./obj_dir/sim)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

/* test/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
    input  logic         clk_i,
    input  logic         cmd_i,
    input  logic         cmd_oe_i,
    input  int           mode_i,
    input  logic [5:0]   exp_index_i,
    input  logic [31:0]  exp_arg_i,
    input  logic [119:0] payload_i,
    input  logic         abort_ok_i,
    output logic         cmd_o,
    output int           frame_cnt_o,
    output int           err_cnt_o
);

    localparam int MODE_LONG      = 1;
    localparam int MODE_BAD_CRC   = 2;
    localparam int MODE_BAD_INDEX = 3;
    localparam int MODE_SILENT    = 4;

    logic        line_q  = 1'b1;
    logic [47:0] frame_q = '0;
    int          bit_cnt = 0;
    int          frames  = 0;
    int          errs    = 0;

    assign cmd_o       = line_q;
    assign frame_cnt_o = frames;
    assign err_cnt_o   = errs;

    // CRC7 over the low len bits, MSB first
    function automatic logic [6:0] crc7_bits(input logic [135:0] data, input int len);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = len - 1; i >= 0; i--) begin
            fb  = crc[6] ^ data[i];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    task automatic report(input string name, input logic [47:0] got, input logic [47:0] exp);
        assert (got === exp)
        else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_frame();
        report("frame start bit", 48'(frame_q[47]), 48'd0);
        report("frame transmit bit", 48'(frame_q[46]), 48'd1);
        report("frame index", 48'(frame_q[45:40]), 48'(exp_index_i));
        report("frame argument", 48'(frame_q[39:8]), 48'(exp_arg_i));
        report("frame crc7", 48'(frame_q[7:1]), 48'(crc7_bits(136'(frame_q[47:8]), 40)));
        report("frame end bit", 48'(frame_q[0]), 48'd1);
    endtask

    task automatic send_response();
        logic [135:0] resp;
        logic [5:0]   idx;
        logic [6:0]   crc;
        int           len;
        resp = '0;
        if (mode_i == MODE_LONG) begin
            len  = 136;
            resp = {8'h3F, payload_i, 8'h01};
            crc  = crc7_bits(resp >> 8, 120);
        end else begin
            len        = 48;
            idx        = frame_q[45:40] ^ ((mode_i == MODE_BAD_INDEX) ? 6'h01 : 6'h00);
            resp[47:0] = {2'b00, idx, payload_i[31:0], 8'h01};
            crc        = crc7_bits(resp >> 8, 40);
        end
        if (mode_i == MODE_BAD_CRC) begin
            crc = crc ^ 7'h01;
        end
        resp[7:1] = crc;
        if (mode_i != MODE_SILENT) begin
            repeat (4) @(posedge clk_i);
            for (int i = len - 1; i >= 0; i--) begin
                #2 line_q = resp[i];
                @(posedge clk_i);
            end
            #2 line_q = 1'b1;
        end
    endtask

    // Frame bits are taken at the falling edge, away from host updates
    always @(negedge clk_i) begin
        if (cmd_oe_i) begin
            frame_q = {frame_q[46:0], cmd_i};
            bit_cnt++;
            if (bit_cnt == 48) begin
                @(negedge clk_i);
                report("cmd_oe_o after 48 bits", 48'(cmd_oe_i), 48'd0);
                check_frame();
                frames++;
                bit_cnt = 0;
                send_response();
            end
        end else if (bit_cnt != 0) begin
            assert (abort_ok_i)
            else begin
                $display("cmd_oe_o dropped after %0d frame bits at %0t ns", bit_cnt, $time);
                errs++;
            end
            bit_cnt = 0;
        end
    end

endmodule

/* test/tb_sd_emmc_controller.sv */
`timescale 1ns/1ps
`include "sd_defines.svh"

module tb_sd_emmc_controller;

    localparam int MODE_SHORT     = 0;
    localparam int MODE_LONG      = 1;
    localparam int MODE_BAD_CRC   = 2;
    localparam int MODE_BAD_INDEX = 3;
    localparam int MODE_SILENT    = 4;
    localparam int WAIT_LIMIT     = 400;

    logic            sd_clk    = 1'b0;
    logic            reset_i   = 1'b1;
    sd_pkg::wb_req_t wb_req    = '0;
    sd_pkg::wb_rsp_t wb_rsp;
    logic            cmd_line;
    logic            cmd_o;
    logic            cmd_oe;
    logic            interrupt;
    int              card_mode = MODE_SHORT;
    logic [5:0]      exp_index = '0;
    logic [31:0]     exp_arg   = '0;
    logic [119:0]    payload   = '0;
    logic            abort_ok  = 1'b0;
    logic [31:0]     rng       = 32'h28c2_36a9;
    logic [3:0]      int_en    = '0;
    int              frame_cnt;
    int              card_errors;
    int              errors      = 0;
    int              ack_errors  = 0;
    int              idle_errors = 0;
    int              total;

    sd_emmc_controller dut (
        .sd_clk      (sd_clk),
        .reset_i     (reset_i),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .cmd_i       (cmd_line),
        .cmd_o       (cmd_o),
        .cmd_oe_o    (cmd_oe),
        .interrupt_o (interrupt)
    );

    sd_card_model card (
        .clk_i       (sd_clk),
        .cmd_i       (cmd_o),
        .cmd_oe_i    (cmd_oe),
        .mode_i      (card_mode),
        .exp_index_i (exp_index),
        .exp_arg_i   (exp_arg),
        .payload_i   (payload),
        .abort_ok_i  (abort_ok),
        .cmd_o       (cmd_line),
        .frame_cnt_o (frame_cnt),
        .err_cnt_o   (card_errors)
    );

    initial begin
        forever #20 sd_clk = ~sd_clk;
    end

    // Ack lasts one cycle
    assert property (@(posedge sd_clk) disable iff (reset_i)
                     !(wb_rsp.ack && $past(wb_rsp.ack)))
    else begin
        $display("Wishbone ack held longer than one cycle at %0t ns", $time);
        ack_errors++;
    end

    // Released line idles high
    assert property (@(posedge sd_clk) disable iff (reset_i) !cmd_oe |-> cmd_o)
    else begin
        $display("cmd_o low while cmd_oe_o is low at %0t ns", $time);
        idle_errors++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s at %0t ns", why, $time);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge sd_clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge sd_clk);
        while (!wb_rsp.ack) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("no Wishbone ack");
            end
            @(negedge sd_clk);
        end
        rdata = wb_rsp.dat;
        @(posedge sd_clk);
        #2 wb_req = '0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic wait_done();
        logic [31:0] s;
        int          n;
        n = 0;
        wb_read(`SD_REG_INT_STATUS, s);
        while (!s[`SD_INT_CMD_DONE]) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("command never signalled DONE");
            end
            wb_read(`SD_REG_INT_STATUS, s);
        end
    endtask

    task automatic wait_oe(input logic level);
        int n;
        n = 0;
        @(negedge sd_clk);
        while (cmd_oe !== level) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("cmd_oe_o never reached the expected level");
            end
            @(negedge sd_clk);
        end
    endtask

    task automatic new_command(input int mode);
        logic [31:0] r;
        next_rand(r);
        exp_arg = r;
        next_rand(r);
        exp_index = r[5:0];
        next_rand(r);
        payload[31:0] = r;
        next_rand(r);
        payload[63:32] = r;
        next_rand(r);
        payload[95:64] = r;
        next_rand(r);
        payload[119:96] = r[23:0];
        card_mode = mode;
    endtask

    task automatic run_cmd(input int mode, input logic [1:0] rtype, input logic crc_chk,
                           input logic idx_chk, input logic twice, input logic [3:0] exp_status);
        logic [31:0] cmd;
        logic [31:0] r;
        int          frames_before;
        new_command(mode);
        cmd           = {22'b0, idx_chk, crc_chk, rtype, exp_index};
        frames_before = frame_cnt;
        wb_write(`SD_REG_ARGUMENT, exp_arg);
        wb_write(`SD_REG_COMMAND, cmd);
        // Lands while the first command is still running
        if (twice) begin
            wb_write(`SD_REG_COMMAND, cmd);
        end
        wait_done();
        // Room for a stray second frame to reach the card
        if (twice) begin
            repeat (2 * `SD_CMD_FRAME_W) @(posedge sd_clk);
        end
        wb_read(`SD_REG_INT_STATUS, r);
        check_val("int_status", r, {28'b0, exp_status});
        check_val("frame_count", frame_cnt, frames_before + 1);
        if (mode == MODE_SHORT || mode == MODE_LONG) begin
            wb_read(`SD_REG_RESP0, r);
            check_val("resp0", r, payload[31:0]);
        end
        if (mode == MODE_LONG) begin
            wb_read(`SD_REG_RESP1, r);
            check_val("resp1", r, payload[63:32]);
            wb_read(`SD_REG_RESP2, r);
            check_val("resp2", r, payload[95:64]);
            wb_read(`SD_REG_RESP3, r);
            check_val("resp3", r, {8'b0, payload[119:96]});
        end
        @(negedge sd_clk);
        check_val("interrupt_o", {31'b0, interrupt}, {31'b0, |(exp_status & int_en)});
        wb_write(`SD_REG_INT_STATUS, 32'h0000_000F);
        wb_read(`SD_REG_INT_STATUS, r);
        check_val("int_status after clear", r, 32'h0);
        @(negedge sd_clk);
        check_val("interrupt_o after clear", {31'b0, interrupt}, 32'h0);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        repeat (2) @(posedge sd_clk);
        #2 reset_i = 1'b0;

        next_rand(r);
        wb_write(`SD_REG_ARGUMENT, r);
        wb_read(`SD_REG_ARGUMENT, d);
        check_val("argument", d, r);
        int_en = 4'hF;
        wb_write(`SD_REG_INT_ENABLE, 32'h0000_000F);
        wb_read(`SD_REG_INT_ENABLE, d);
        check_val("int_enable", d, 32'h0000_000F);
        wb_read(8'h24, d);
        check_val("unused 0x24", d, 32'h0);
        wb_read(8'h3C, d);
        check_val("unused 0x3C", d, 32'h0);

        run_cmd(MODE_SHORT, 2'd1, 1'b1, 1'b1, 1'b1, 4'h1);
        run_cmd(MODE_LONG, 2'd2, 1'b1, 1'b1, 1'b0, 4'h1);
        run_cmd(MODE_BAD_CRC, 2'd1, 1'b1, 1'b0, 1'b0, 4'h5);
        run_cmd(MODE_BAD_CRC, 2'd1, 1'b0, 1'b0, 1'b0, 4'h1);
        run_cmd(MODE_BAD_INDEX, 2'd1, 1'b0, 1'b1, 1'b0, 4'h9);
        run_cmd(MODE_BAD_INDEX, 2'd1, 1'b0, 1'b0, 1'b0, 4'h1);
        run_cmd(MODE_SILENT, 2'd1, 1'b1, 1'b1, 1'b0, 4'h3);

        // Only TIMEOUT raises the interrupt now
        int_en = 4'h2;
        wb_write(`SD_REG_INT_ENABLE, 32'h0000_0002);
        run_cmd(MODE_SHORT, 2'd1, 1'b1, 1'b1, 1'b0, 4'h1);
        run_cmd(MODE_SILENT, 2'd1, 1'b1, 1'b1, 1'b0, 4'h3);

        // Soft reset in the middle of a frame
        abort_ok = 1'b1;
        new_command(MODE_SHORT);
        wb_write(`SD_REG_COMMAND, {22'b0, 2'b11, 2'd1, exp_index});
        wait_oe(1'b1);
        repeat (10) @(posedge sd_clk);
        wb_write(`SD_REG_SOFT_RESET, 32'h0000_0001);
        wait_oe(1'b0);
        repeat (2) @(posedge sd_clk);
        abort_ok = 1'b0;
        wb_read(`SD_REG_INT_STATUS, d);
        check_val("int_status after soft reset", d, 32'h0);
        run_cmd(MODE_SHORT, 2'd1, 1'b1, 1'b1, 1'b0, 4'h1);

        repeat (5) @(posedge sd_clk);
        total = errors + ack_errors + idle_errors + card_errors;
        $display("Errors: checks=%0d ack=%0d idle=%0d card=%0d",
                 errors, ack_errors, idle_errors, card_errors);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
